//--- rtl/ooo_pkg.sv
// Out-of-order dispatch package with operand widths, vector types and the station class table

package ooo_pkg;

    // Operand and tag widths shared by the switch and the stations
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 5;
    localparam int OPC_WIDTH  = 4;

    // One CDB lane per reservation station
    localparam int NUM_RS   = 3;
    localparam int RS_DEPTH = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [OPC_WIDTH-1:0]  opc_t;
    typedef logic [NUM_RS-1:0]     rs_mask_t;

    // Functional unit class that an instruction needs
    typedef enum logic {
        OP_IEU,
        OP_LSU
    } op_class_e;

    // Class of the unit behind each station, indexed by station number
    localparam op_class_e RS_CLASS [NUM_RS] = '{OP_IEU, OP_IEU, OP_LSU};

    // Per-entry state inside a reservation station
    typedef enum logic [1:0] {
        RS_EMPTY,
        RS_WAIT,
        RS_READY
    } rs_state_e;

endpackage

//--- rtl/rs_enq_if.sv
// Enqueue channel carrying one renamed instruction from the dispatch switch into a station
`timescale 1ns/1ps

interface rs_enq_if;

    logic           enq_valid;
    ooo_pkg::opc_t  opc;
    ooo_pkg::tag_t  dst_tag;
    logic           src_rdy  [2];
    ooo_pkg::tag_t  src_tag  [2];
    ooo_pkg::data_t src_data [2];
    logic           full;

    modport switch (
        output enq_valid, opc, dst_tag, src_rdy, src_tag, src_data,
        input  full
    );

    modport station (
        input  enq_valid, opc, dst_tag, src_rdy, src_tag, src_data,
        output full
    );

endinterface

//--- rtl/rr_picker.sv
// Round-robin picker granting one request per cycle from a rotating priority pointer
`timescale 1ns/1ps

module rr_picker (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_advance,
    input  ooo_pkg::rs_mask_t i_req,
    output ooo_pkg::rs_mask_t o_grant
);

    typedef logic [$clog2(ooo_pkg::NUM_RS)-1:0] ptr_t;

    ptr_t ptr_q;
    int   grant_idx;

    // Search upward from the pointer and wrap, so the pointer position has top priority
    always_comb begin
        int   idx;
        logic found;
        o_grant   = '0;
        grant_idx = 0;
        found     = 1'b0;
        for (int k = 0; k < ooo_pkg::NUM_RS; k++) begin
            idx = (int'(ptr_q) + k) % ooo_pkg::NUM_RS;
            if (!found && i_req[idx]) begin
                found        = 1'b1;
                o_grant[idx] = 1'b1;
                grant_idx    = idx;
            end
        end
    end

    // The winner drops to lowest priority once its request is taken
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ptr_q <= '0;
        end else if (i_advance && (|o_grant)) begin
            ptr_q <= (grant_idx == ooo_pkg::NUM_RS - 1) ? '0 : ptr_t'(grant_idx + 1);
        end
    end

endmodule

//--- rtl/rs_switch.sv
// Dispatch switch that steers each instruction to a capable station and bypasses CDB results
`timescale 1ns/1ps

module rs_switch (
    input  logic               clk,
    input  logic               i_arst_n,

    input  logic               i_disp_valid,
    output logic               o_disp_ready,
    input  ooo_pkg::op_class_e i_disp_class,
    input  ooo_pkg::opc_t      i_disp_opc,
    input  ooo_pkg::tag_t      i_disp_dst_tag,

    input  logic               i_src_rdy  [2],
    input  ooo_pkg::tag_t      i_src_tag  [2],
    input  ooo_pkg::data_t     i_src_data [2],

    input  logic               i_cdb_en   [ooo_pkg::NUM_RS],
    input  ooo_pkg::tag_t      i_cdb_tag  [ooo_pkg::NUM_RS],
    input  ooo_pkg::data_t     i_cdb_data [ooo_pkg::NUM_RS],

    rs_enq_if.switch           o_enq      [ooo_pkg::NUM_RS]
);

    ooo_pkg::rs_mask_t      supported;
    ooo_pkg::rs_mask_t      grant;
    wire ooo_pkg::rs_mask_t full_vec;
    logic                   accept;

    logic                   byp_rdy  [2];
    ooo_pkg::data_t         byp_data [2];

    // Stations whose unit can execute this class
    always_comb begin
        for (int r = 0; r < ooo_pkg::NUM_RS; r++) begin
            supported[r] = (ooo_pkg::RS_CLASS[r] == i_disp_class);
        end
    end

    rr_picker station_picker (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_advance (accept),
        .i_req     (supported),
        .o_grant   (grant)
    );

    // Only the picked station's full flag matters, even if a sibling has room
    assign o_disp_ready = (|grant) & ~(|(grant & full_vec));
    assign accept       = i_disp_valid & o_disp_ready;

    // A waiting source picks up a result that is broadcast in the same cycle
    // Sources that arrive ready keep their own value even on a tag match
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            byp_rdy[s]  = i_src_rdy[s];
            byp_data[s] = i_src_data[s];
            for (int l = 0; l < ooo_pkg::NUM_RS; l++) begin
                if (!i_src_rdy[s] && i_cdb_en[l] && (i_cdb_tag[l] == i_src_tag[s])) begin
                    byp_rdy[s]  = 1'b1;
                    byp_data[s] = i_cdb_data[l];
                end
            end
        end
    end

    // Payload fans out to every station, the valid goes only to the granted one
    for (genvar g = 0; g < ooo_pkg::NUM_RS; g++) begin : g_enq
        assign o_enq[g].enq_valid = accept & grant[g];
        assign o_enq[g].opc       = i_disp_opc;
        assign o_enq[g].dst_tag   = i_disp_dst_tag;
        assign o_enq[g].src_rdy   = byp_rdy;
        assign o_enq[g].src_tag   = i_src_tag;
        assign o_enq[g].src_data  = byp_data;
        assign full_vec[g]        = o_enq[g].full;
    end

endmodule

//--- rtl/reservation_station.sv
// Reservation station with a collapsing entry queue, CDB wakeup and oldest-ready issue
`timescale 1ns/1ps

module reservation_station (
    input  logic           clk,
    input  logic           i_arst_n,

    rs_enq_if.station      i_enq,

    input  logic           i_cdb_en   [ooo_pkg::NUM_RS],
    input  ooo_pkg::tag_t  i_cdb_tag  [ooo_pkg::NUM_RS],
    input  ooo_pkg::data_t i_cdb_data [ooo_pkg::NUM_RS],

    output logic           o_iss_valid,
    input  logic           i_iss_ready,
    output ooo_pkg::opc_t  o_iss_opc,
    output ooo_pkg::tag_t  o_iss_dst_tag,
    output ooo_pkg::data_t o_iss_src_a,
    output ooo_pkg::data_t o_iss_src_b
);

    // Entry 0 is always the oldest occupied slot
    ooo_pkg::rs_state_e state_q [ooo_pkg::RS_DEPTH];
    ooo_pkg::rs_state_e state_d [ooo_pkg::RS_DEPTH];
    ooo_pkg::opc_t      opc_q   [ooo_pkg::RS_DEPTH];
    ooo_pkg::opc_t      opc_d   [ooo_pkg::RS_DEPTH];
    ooo_pkg::tag_t      dst_q   [ooo_pkg::RS_DEPTH];
    ooo_pkg::tag_t      dst_d   [ooo_pkg::RS_DEPTH];
    logic               rdy_q   [ooo_pkg::RS_DEPTH][2];
    logic               rdy_d   [ooo_pkg::RS_DEPTH][2];
    ooo_pkg::tag_t      tag_q   [ooo_pkg::RS_DEPTH][2];
    ooo_pkg::tag_t      tag_d   [ooo_pkg::RS_DEPTH][2];
    ooo_pkg::data_t     data_q  [ooo_pkg::RS_DEPTH][2];
    ooo_pkg::data_t     data_d  [ooo_pkg::RS_DEPTH][2];

    // Sources after this cycle's CDB snoop
    logic               wk_rdy  [ooo_pkg::RS_DEPTH][2];
    ooo_pkg::data_t     wk_data [ooo_pkg::RS_DEPTH][2];

    int                 iss_idx;
    logic               iss_fire;

    always_comb begin
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                wk_rdy[i][s]  = rdy_q[i][s];
                wk_data[i][s] = data_q[i][s];
                for (int l = 0; l < ooo_pkg::NUM_RS; l++) begin
                    if (!rdy_q[i][s] && i_cdb_en[l] && (i_cdb_tag[l] == tag_q[i][s])) begin
                        wk_rdy[i][s]  = 1'b1;
                        wk_data[i][s] = i_cdb_data[l];
                    end
                end
            end
        end
    end

    // Walking down from the top leaves the lowest ready index, which is the oldest
    always_comb begin
        o_iss_valid = 1'b0;
        iss_idx     = 0;
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == ooo_pkg::RS_READY) begin
                o_iss_valid = 1'b1;
                iss_idx     = i;
            end
        end
    end

    assign iss_fire      = o_iss_valid & i_iss_ready;
    assign o_iss_opc     = opc_q[iss_idx];
    assign o_iss_dst_tag = dst_q[iss_idx];
    assign o_iss_src_a   = data_q[iss_idx][0];
    assign o_iss_src_b   = data_q[iss_idx][1];

    assign i_enq.full = (state_q[ooo_pkg::RS_DEPTH-1] != ooo_pkg::RS_EMPTY);

    // Entries above an issued slot slide down by one and the new entry lands behind them
    always_comb begin
        int src;
        int count;
        int wr_pos;
        count = 0;
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            if (state_q[i] != ooo_pkg::RS_EMPTY) begin
                count = count + 1;
            end
        end
        wr_pos = iss_fire ? count - 1 : count;

        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            src        = (iss_fire && (i >= iss_idx)) ? i + 1 : i;
            state_d[i] = ooo_pkg::RS_EMPTY;
            opc_d[i]   = opc_q[i];
            dst_d[i]   = dst_q[i];
            for (int s = 0; s < 2; s++) begin
                rdy_d[i][s]  = rdy_q[i][s];
                tag_d[i][s]  = tag_q[i][s];
                data_d[i][s] = data_q[i][s];
            end

            if (src < ooo_pkg::RS_DEPTH) begin
                opc_d[i] = opc_q[src];
                dst_d[i] = dst_q[src];
                for (int s = 0; s < 2; s++) begin
                    rdy_d[i][s]  = wk_rdy[src][s];
                    tag_d[i][s]  = tag_q[src][s];
                    data_d[i][s] = wk_data[src][s];
                end
                if (state_q[src] != ooo_pkg::RS_EMPTY) begin
                    state_d[i] = (wk_rdy[src][0] && wk_rdy[src][1]) ? ooo_pkg::RS_READY
                                                                    : ooo_pkg::RS_WAIT;
                end
            end

            if (i_enq.enq_valid && (i == wr_pos)) begin
                opc_d[i] = i_enq.opc;
                dst_d[i] = i_enq.dst_tag;
                for (int s = 0; s < 2; s++) begin
                    rdy_d[i][s]  = i_enq.src_rdy[s];
                    tag_d[i][s]  = i_enq.src_tag[s];
                    data_d[i][s] = i_enq.src_data[s];
                end
                state_d[i] = (i_enq.src_rdy[0] && i_enq.src_rdy[1]) ? ooo_pkg::RS_READY
                                                                    : ooo_pkg::RS_WAIT;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= '{default: ooo_pkg::RS_EMPTY};
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        opc_q  <= opc_d;
        dst_q  <= dst_d;
        rdy_q  <= rdy_d;
        tag_q  <= tag_d;
        data_q <= data_d;
    end

endmodule

//--- rtl/rs_dispatch_top.sv
// Dispatch top joining the station switch with two integer stations and one load/store station
`timescale 1ns/1ps

module rs_dispatch_top (
    input  logic               clk,
    input  logic               i_arst_n,

    input  logic               i_disp_valid,
    output logic               o_disp_ready,
    input  ooo_pkg::op_class_e i_disp_class,
    input  ooo_pkg::opc_t      i_disp_opc,
    input  ooo_pkg::tag_t      i_disp_dst_tag,
    input  logic               i_src_rdy  [2],
    input  ooo_pkg::tag_t      i_src_tag  [2],
    input  ooo_pkg::data_t     i_src_data [2],

    input  logic               i_cdb_en   [ooo_pkg::NUM_RS],
    input  ooo_pkg::tag_t      i_cdb_tag  [ooo_pkg::NUM_RS],
    input  ooo_pkg::data_t     i_cdb_data [ooo_pkg::NUM_RS],

    output logic               o_iss_valid   [ooo_pkg::NUM_RS],
    input  logic               i_iss_ready   [ooo_pkg::NUM_RS],
    output ooo_pkg::opc_t      o_iss_opc     [ooo_pkg::NUM_RS],
    output ooo_pkg::tag_t      o_iss_dst_tag [ooo_pkg::NUM_RS],
    output ooo_pkg::data_t     o_iss_src_a   [ooo_pkg::NUM_RS],
    output ooo_pkg::data_t     o_iss_src_b   [ooo_pkg::NUM_RS]
);

    rs_enq_if enq_bus [ooo_pkg::NUM_RS] ();

    rs_switch rs_switch (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_disp_valid   (i_disp_valid),
        .o_disp_ready   (o_disp_ready),
        .i_disp_class   (i_disp_class),
        .i_disp_opc     (i_disp_opc),
        .i_disp_dst_tag (i_disp_dst_tag),
        .i_src_rdy      (i_src_rdy),
        .i_src_tag      (i_src_tag),
        .i_src_data     (i_src_data),
        .i_cdb_en       (i_cdb_en),
        .i_cdb_tag      (i_cdb_tag),
        .i_cdb_data     (i_cdb_data),
        .o_enq          (enq_bus)
    );

    // Station number matches its position in the class table and its CDB lane
    for (genvar g = 0; g < ooo_pkg::NUM_RS; g++) begin : g_rs
        reservation_station station (
            .clk           (clk),
            .i_arst_n      (i_arst_n),
            .i_enq         (enq_bus[g]),
            .i_cdb_en      (i_cdb_en),
            .i_cdb_tag     (i_cdb_tag),
            .i_cdb_data    (i_cdb_data),
            .o_iss_valid   (o_iss_valid[g]),
            .i_iss_ready   (i_iss_ready[g]),
            .o_iss_opc     (o_iss_opc[g]),
            .o_iss_dst_tag (o_iss_dst_tag[g]),
            .o_iss_src_a   (o_iss_src_a[g]),
            .o_iss_src_b   (o_iss_src_b[g])
        );
    end

endmodule

//--- dv/rs_dispatch_tb.sv
// Testbench for the dispatch switch and its reservation stations, checked against a queue model
`timescale 1ns/1ps

module rs_dispatch_tb;

    localparam int NUM_RS         = ooo_pkg::NUM_RS;
    localparam int NUM_ROWS       = 24;
    localparam int TIMEOUT_CYCLES = 16 + NUM_ROWS * 40;
    localparam ooo_pkg::op_class_e IEU = ooo_pkg::OP_IEU;
    localparam ooo_pkg::op_class_e LSU = ooo_pkg::OP_LSU;

    // One table row is one clock cycle of stimulus
    typedef struct packed {
        logic                disp;
        ooo_pkg::op_class_e  cls;
        ooo_pkg::opc_t       opc;
        ooo_pkg::tag_t       dst;
        logic [1:0]          srdy;
        ooo_pkg::tag_t [1:0] stag;
        ooo_pkg::rs_mask_t   cdb_en;
        ooo_pkg::tag_t       ctag;
        ooo_pkg::rs_mask_t   iss;
    } row_t;

    typedef struct packed {
        ooo_pkg::opc_t        opc;
        ooo_pkg::tag_t        dst;
        logic [1:0]           rdy;
        ooo_pkg::tag_t [1:0]  tag;
        ooo_pkg::data_t [1:0] data;
    } entry_t;

    logic               clk;
    logic               i_arst_n;
    logic               i_disp_valid;
    logic               o_disp_ready;
    ooo_pkg::op_class_e i_disp_class;
    ooo_pkg::opc_t      i_disp_opc;
    ooo_pkg::tag_t      i_disp_dst_tag;
    logic               i_src_rdy     [2];
    ooo_pkg::tag_t      i_src_tag     [2];
    ooo_pkg::data_t     i_src_data    [2];
    logic               i_cdb_en      [NUM_RS];
    ooo_pkg::tag_t      i_cdb_tag     [NUM_RS];
    ooo_pkg::data_t     i_cdb_data    [NUM_RS];
    logic               o_iss_valid   [NUM_RS];
    logic               i_iss_ready   [NUM_RS];
    ooo_pkg::opc_t      o_iss_opc     [NUM_RS];
    ooo_pkg::tag_t      o_iss_dst_tag [NUM_RS];
    ooo_pkg::data_t     o_iss_src_a   [NUM_RS];
    ooo_pkg::data_t     o_iss_src_b   [NUM_RS];

    row_t   rows     [NUM_ROWS];
    string  row_name [NUM_ROWS];
    int     row_count;
    // Expected contents of each station in arrival order
    entry_t model_q  [NUM_RS][$];
    int     pick_ptr;
    int     error_count;
    int     seed;
    logic   hold_disp;

    rs_dispatch_top i_rs_dispatch_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the table and the drain did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_row(input string name, input logic disp, input ooo_pkg::op_class_e cls,
                           input ooo_pkg::opc_t opc, input ooo_pkg::tag_t dst,
                           input logic [1:0] srdy, input ooo_pkg::tag_t stag1,
                           input ooo_pkg::tag_t stag0, input ooo_pkg::rs_mask_t cdb_en,
                           input ooo_pkg::tag_t ctag, input ooo_pkg::rs_mask_t iss);
        row_name[row_count] = name;
        rows[row_count]     = '{disp, cls, opc, dst, srdy, {stag1, stag0}, cdb_en, ctag, iss};
        row_count++;
    endtask

    // Same search as the round-robin rule, upward from the pointer with wrap
    function automatic int pick_station(input ooo_pkg::op_class_e cls);
        int idx;
        for (int k = 0; k < NUM_RS; k++) begin
            idx = (pick_ptr + k) % NUM_RS;
            if (ooo_pkg::RS_CLASS[idx] == cls) begin
                return idx;
            end
        end
        return 0;
    endfunction

    function automatic int oldest_ready(input int st);
        for (int i = 0; i < model_q[st].size(); i++) begin
            if (&model_q[st][i].rdy) begin
                return i;
            end
        end
        return -1;
    endfunction

    // A waiting source takes the data of a CDB lane carrying its tag
    function automatic entry_t snoop_cdb(input entry_t e);
        entry_t r;
        r = e;
        for (int s = 0; s < 2; s++) begin
            for (int l = 0; l < NUM_RS; l++) begin
                if (!e.rdy[s] && i_cdb_en[l] && (i_cdb_tag[l] == e.tag[s])) begin
                    r.rdy[s]  = 1'b1;
                    r.data[s] = i_cdb_data[l];
                end
            end
        end
        return r;
    endfunction

    function automatic int queued_total();
        int n;
        n = 0;
        for (int st = 0; st < NUM_RS; st++) begin
            n += model_q[st].size();
        end
        return n;
    endfunction

    task automatic drive_row(input int r);
        @(negedge clk);
        i_disp_valid   = rows[r].disp;
        i_disp_class   = rows[r].cls;
        i_disp_opc     = rows[r].opc;
        i_disp_dst_tag = rows[r].dst;
        for (int s = 0; s < 2; s++) begin
            i_src_rdy[s] = rows[r].srdy[s];
            i_src_tag[s] = rows[r].stag[s];
            // A refused instruction is presented again with the same operands
            if (!hold_disp) begin
                i_src_data[s] = $random(seed);
            end
        end
        for (int l = 0; l < NUM_RS; l++) begin
            i_cdb_en[l]    = rows[r].cdb_en[l];
            i_cdb_tag[l]   = rows[r].ctag;
            i_cdb_data[l]  = $random(seed);
            i_iss_ready[l] = rows[r].iss[l];
        end
    endtask

    // Checks one rising edge, then moves the model to the state after it
    task automatic step_cycle(input string name);
        int     pick;
        int     idx;
        logic   exp_rdy;
        entry_t e;
        @(posedge clk);
        pick    = 0;
        exp_rdy = 1'b0;
        if (i_disp_valid) begin
            pick    = pick_station(i_disp_class);
            exp_rdy = (model_q[pick].size() < ooo_pkg::RS_DEPTH);
            check_value($sformatf("%s disp_ready", name), 32'(exp_rdy), 32'(o_disp_ready));
        end
        for (int st = 0; st < NUM_RS; st++) begin
            idx = oldest_ready(st);
            check_value($sformatf("%s rs%0d valid", name, st), 32'(idx >= 0),
                        32'(o_iss_valid[st]));
            if ((idx >= 0) && i_iss_ready[st]) begin
                e = model_q[st][idx];
                check_value($sformatf("%s rs%0d opc", name, st), 32'(e.opc), 32'(o_iss_opc[st]));
                check_value($sformatf("%s rs%0d dst", name, st), 32'(e.dst),
                            32'(o_iss_dst_tag[st]));
                check_value($sformatf("%s rs%0d src_a", name, st), e.data[0], o_iss_src_a[st]);
                check_value($sformatf("%s rs%0d src_b", name, st), e.data[1], o_iss_src_b[st]);
                model_q[st].delete(idx);
            end
            for (int i = 0; i < model_q[st].size(); i++) begin
                model_q[st][i] = snoop_cdb(model_q[st][i]);
            end
        end
        if (exp_rdy) begin
            e.opc = i_disp_opc;
            e.dst = i_disp_dst_tag;
            for (int s = 0; s < 2; s++) begin
                e.rdy[s]  = i_src_rdy[s];
                e.tag[s]  = i_src_tag[s];
                e.data[s] = i_src_data[s];
            end
            model_q[pick].push_back(snoop_cdb(e));
            pick_ptr = (pick + 1) % NUM_RS;
        end
        hold_disp = i_disp_valid && !exp_rdy;
    endtask

    initial begin
        seed           = 32'h907bdedf;
        error_count    = 0;
        row_count      = 0;
        pick_ptr       = 0;
        hold_disp      = 1'b0;
        i_arst_n       = 1'b0;
        i_disp_valid   = 1'b0;
        i_disp_class   = IEU;
        i_disp_opc     = '0;
        i_disp_dst_tag = '0;
        i_src_rdy      = '{default: 1'b0};
        i_src_tag      = '{default: '0};
        i_src_data     = '{default: '0};
        i_cdb_en       = '{default: 1'b0};
        i_cdb_tag      = '{default: '0};
        i_cdb_data     = '{default: '0};
        i_iss_ready    = '{default: 1'b1};

        // Columns: name, valid, class, opc, dst, src rdy, tag1, tag0, cdb lanes, cdb tag, iss ready
        add_row("route_ieu0", 1'b1, IEU, 4'h1, 5'd1, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("route_ieu1", 1'b1, IEU, 4'h2, 5'd2, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("route_lsu0", 1'b1, LSU, 4'h3, 5'd3, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("route_ieu2", 1'b1, IEU, 4'h4, 5'd4, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("route_ieu3", 1'b1, IEU, 4'h5, 5'd5, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("route_lsu1", 1'b1, LSU, 4'h6, 5'd6, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        // Source 1 waits on tag 9 seen on lane 1, source 0 is ready with the same tag
        add_row("bypass", 1'b1, IEU, 4'h7, 5'd7, 2'b01, 5'd9, 5'd9, 3'b010, 5'd9, 3'b111);
        add_row("wake_old", 1'b1, IEU, 4'h8, 5'd8, 2'b10, 5'd3, 5'd12, 3'b000, '0, 3'b111);
        add_row("wake_mid", 1'b1, IEU, 4'h9, 5'd10, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("wake_young", 1'b1, IEU, 4'ha, 5'd11, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("wake_cdb", 1'b0, IEU, 4'h0, 5'd0, 2'b11, '0, '0, 3'b001, 5'd12, 3'b111);
        add_row("wake_idle", 1'b0, IEU, 4'h0, 5'd0, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        for (int k = 0; k < 8; k++) begin
            add_row($sformatf("bp_fill%0d", k), 1'b1, IEU, ooo_pkg::opc_t'(k + 11),
                    ooo_pkg::tag_t'(k + 13), 2'b11, '0, '0, 3'b000, '0, 3'b110);
        end
        // The same instruction is offered until station 0 makes room for it
        add_row("bp_blocked", 1'b1, IEU, 4'h4, 5'd21, 2'b11, '0, '0, 3'b000, '0, 3'b110);
        add_row("bp_retry", 1'b1, IEU, 4'h4, 5'd21, 2'b11, '0, '0, 3'b000, '0, 3'b110);
        add_row("bp_release", 1'b1, IEU, 4'h4, 5'd21, 2'b11, '0, '0, 3'b000, '0, 3'b111);
        add_row("bp_accept", 1'b1, IEU, 4'h4, 5'd21, 2'b11, '0, '0, 3'b000, '0, 3'b111);

        repeat (16) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        @(posedge clk);
        for (int st = 0; st < NUM_RS; st++) begin
            check_value($sformatf("reset rs%0d valid", st), 32'd0, 32'(o_iss_valid[st]));
        end
        check_value("reset disp_ready", 32'd1, 32'(o_disp_ready));

        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_row(r);
            step_cycle(row_name[r]);
        end

        // Drain every station so that nothing queued is lost
        @(negedge clk);
        i_disp_valid = 1'b0;
        i_cdb_en     = '{default: 1'b0};
        i_iss_ready  = '{default: 1'b1};
        while (queued_total() > 0) begin
            step_cycle("drain");
        end
        repeat (2) step_cycle("quiet");

        $display("Summary: %0d table rows, %0d errors", NUM_ROWS, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/ooo_pkg.sv
rtl/rs_enq_if.sv
rtl/rr_picker.sv
rtl/rs_switch.sv
rtl/reservation_station.sv
rtl/rs_dispatch_top.sv
dv/rs_dispatch_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --timing --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= -Wall
TOP        ?= rs_dispatch_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
